//--- source/io_noc_pkg.sv
package io_noc_pkg;

  // Link flit and routing field widths
  localparam int unsigned flit_width_lp = 32;
  localparam int unsigned did_width_lp  = 4;
  localparam int unsigned len_width_lp  = 4;

  // Header flit layout from bit 0 upward
  //   [3:0]   destination did
  //   [7:4]   data flit count
  //   [9:8]   opcode
  //   [11:10] size
  //   [31:12] address
  localparam int unsigned hdr_did_lsb_lp    = 0;
  localparam int unsigned hdr_len_lsb_lp    = hdr_did_lsb_lp + did_width_lp;
  localparam int unsigned hdr_opcode_lsb_lp = hdr_len_lsb_lp + len_width_lp;
  localparam int unsigned hdr_size_lsb_lp   = hdr_opcode_lsb_lp + 2;
  localparam int unsigned hdr_addr_lsb_lp   = hdr_size_lsb_lp + 2;

endpackage

//--- source/bedrock_mem_pkg.sv
package bedrock_mem_pkg;

  // Memory interface widths
  localparam int unsigned paddr_width_lp  = 20;
  localparam int unsigned data_width_lp   = 32;
  localparam int unsigned opcode_width_lp = 2;
  localparam int unsigned size_width_lp   = 2;

  // Opcodes
  localparam logic [opcode_width_lp-1:0] mem_rd_lp = 2'd0;
  localparam logic [opcode_width_lp-1:0] mem_wr_lp = 2'd1;

  // Size s means 2^s beats
  localparam int unsigned max_beats_lp = 8;

  // Address map
  //   [19]    nonlocal
  //   [18:15] hio field holding the destination did of a global address
  //   [14:11] local device number
  localparam int unsigned nonlocal_bit_lp = 19;
  localparam int unsigned hio_lsb_lp      = 15;
  localparam int unsigned dev_lsb_lp      = 11;
  localparam int unsigned dev_width_lp    = 4;

  // Devices served by the host
  localparam logic [dev_width_lp-1:0] boot_dev_lp = 4'd0;
  localparam logic [dev_width_lp-1:0] host_dev_lp = 4'd1;

endpackage

//--- source/io_cmd_encode.sv
`timescale 1ns/10ps

module io_cmd_encode
  (input  logic [io_noc_pkg::did_width_lp-1:0]         host_did_i
   , input  logic [bedrock_mem_pkg::opcode_width_lp-1:0] opcode_i
   , input  logic [bedrock_mem_pkg::paddr_width_lp-1:0]  addr_i
   , input  logic [bedrock_mem_pkg::size_width_lp-1:0]   size_i
   , output logic [io_noc_pkg::flit_width_lp-1:0]        hdr_flit_o
   );

  logic [bedrock_mem_pkg::dev_width_lp-1:0] dev;
  logic                                     is_host_addr;
  logic [io_noc_pkg::did_width_lp-1:0]      dst_did;
  logic [io_noc_pkg::len_width_lp-1:0]      data_len;

  assign dev = addr_i[bedrock_mem_pkg::dev_lsb_lp +: bedrock_mem_pkg::dev_width_lp];

  // Boot and host devices of a local address go to the host
  assign is_host_addr = ~addr_i[bedrock_mem_pkg::nonlocal_bit_lp]
                        && ((dev == bedrock_mem_pkg::boot_dev_lp)
                            || (dev == bedrock_mem_pkg::host_dev_lp));

  assign dst_did = is_host_addr
                   ? host_did_i
                   : addr_i[bedrock_mem_pkg::hio_lsb_lp +: io_noc_pkg::did_width_lp];

  // One flit per beat, so a write carries 2^size flits
  assign data_len = (opcode_i == bedrock_mem_pkg::mem_wr_lp)
                    ? ({{(io_noc_pkg::len_width_lp-1){1'b0}}, 1'b1} << size_i)
                    : '0;

  always_comb begin
    hdr_flit_o = '0;
    hdr_flit_o[io_noc_pkg::hdr_did_lsb_lp +: io_noc_pkg::did_width_lp] = dst_did;
    hdr_flit_o[io_noc_pkg::hdr_len_lsb_lp +: io_noc_pkg::len_width_lp] = data_len;
    hdr_flit_o[io_noc_pkg::hdr_opcode_lsb_lp +: bedrock_mem_pkg::opcode_width_lp] = opcode_i;
    hdr_flit_o[io_noc_pkg::hdr_size_lsb_lp +: bedrock_mem_pkg::size_width_lp] = size_i;
    hdr_flit_o[io_noc_pkg::hdr_addr_lsb_lp +: bedrock_mem_pkg::paddr_width_lp] = addr_i;
  end

endmodule

//--- source/wormhole_sender.sv
`timescale 1ns/10ps

module wormhole_sender
  (input  logic                                      clk_i
   , input  logic                                    reset_i

   , input  logic [io_noc_pkg::flit_width_lp-1:0]    hdr_flit_i
   , input  logic                                    hdr_v_i
   , output logic                                    hdr_ready_o

   , input  logic [bedrock_mem_pkg::data_width_lp-1:0] data_i
   , input  logic                                    data_v_i
   , output logic                                    data_ready_o

   , output logic [io_noc_pkg::flit_width_lp-1:0]    link_data_o
   , output logic                                    link_v_o
   , input  logic                                    link_ready_i
   );

  typedef enum logic [1:0] {
    e_idle,
    e_hdr,
    e_data
  } state_e;

  state_e                              state_r;
  logic [io_noc_pkg::flit_width_lp-1:0] hdr_r;
  logic [io_noc_pkg::len_width_lp-1:0]  count_r;
  logic [io_noc_pkg::len_width_lp-1:0]  hdr_len;

  assign hdr_len = hdr_r[io_noc_pkg::hdr_len_lsb_lp +: io_noc_pkg::len_width_lp];

  // One command in flight
  assign hdr_ready_o = (state_r == e_idle);

  // Data flits stream straight through to the link
  always_comb begin
    link_v_o     = 1'b0;
    link_data_o  = hdr_r;
    data_ready_o = 1'b0;
    case (state_r)
      e_hdr: begin
        link_v_o = 1'b1;
      end
      e_data: begin
        link_v_o     = data_v_i;
        link_data_o  = data_i;
        data_ready_o = link_ready_i;
      end
      default: begin
        link_v_o = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (hdr_v_i && hdr_ready_o) begin
      hdr_r <= hdr_flit_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      count_r <= '0;
    end else begin
      case (state_r)
        e_idle: begin
          if (hdr_v_i) begin
            state_r <= e_hdr;
          end
        end
        e_hdr: begin
          if (link_ready_i) begin
            count_r <= hdr_len;
            state_r <= (hdr_len == '0) ? e_idle : e_data;
          end
        end
        e_data: begin
          if (data_v_i && link_ready_i) begin
            count_r <= count_r - 1'b1;
            if (count_r == 1) begin
              state_r <= e_idle;
            end
          end
        end
        default: begin
          state_r <= e_idle;
        end
      endcase
    end
  end

endmodule

//--- source/wormhole_receiver.sv
`timescale 1ns/10ps

module wormhole_receiver
  (input  logic                                          clk_i
   , input  logic                                        reset_i

   , input  logic [io_noc_pkg::flit_width_lp-1:0]        link_data_i
   , input  logic                                        link_v_i
   , output logic                                        link_ready_o

   , output logic                                        resp_v_o
   , input  logic                                        resp_ready_i
   , output logic [bedrock_mem_pkg::opcode_width_lp-1:0] opcode_o
   , output logic [bedrock_mem_pkg::paddr_width_lp-1:0]  addr_o
   , output logic [bedrock_mem_pkg::size_width_lp-1:0]   size_o

   , output logic [bedrock_mem_pkg::data_width_lp-1:0]   data_o
   , output logic                                        data_v_o
   , output logic                                        last_o
   , input  logic                                        data_ready_i
   );

  typedef enum logic [1:0] {
    e_idle,
    e_hdr,
    e_data
  } state_e;

  state_e                                     state_r;
  logic [bedrock_mem_pkg::opcode_width_lp-1:0] opcode_r;
  logic [bedrock_mem_pkg::paddr_width_lp-1:0]  addr_r;
  logic [bedrock_mem_pkg::size_width_lp-1:0]   size_r;
  logic [io_noc_pkg::len_width_lp-1:0]         count_r;
  logic                                        hdr_accept;

  assign hdr_accept = (state_r == e_idle) && link_v_i;

  assign opcode_o = opcode_r;
  assign addr_o   = addr_r;
  assign size_o   = size_r;
  assign resp_v_o = (state_r == e_hdr);

  // Data beats pass straight through from the link
  assign data_o       = link_data_i;
  assign data_v_o     = (state_r == e_data) && link_v_i;
  assign last_o       = (state_r == e_data) && (count_r == 1);
  assign link_ready_o = (state_r == e_idle) || ((state_r == e_data) && data_ready_i);

  // Header fields held until the response handshake
  always_ff @(posedge clk_i) begin
    if (hdr_accept) begin
      opcode_r <= link_data_i[io_noc_pkg::hdr_opcode_lsb_lp +: bedrock_mem_pkg::opcode_width_lp];
      addr_r   <= link_data_i[io_noc_pkg::hdr_addr_lsb_lp +: bedrock_mem_pkg::paddr_width_lp];
      size_r   <= link_data_i[io_noc_pkg::hdr_size_lsb_lp +: bedrock_mem_pkg::size_width_lp];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      count_r <= '0;
    end else begin
      case (state_r)
        e_idle: begin
          if (link_v_i) begin
            count_r <= link_data_i[io_noc_pkg::hdr_len_lsb_lp +: io_noc_pkg::len_width_lp];
            state_r <= e_hdr;
          end
        end
        e_hdr: begin
          if (resp_ready_i) begin
            state_r <= (count_r == '0) ? e_idle : e_data;
          end
        end
        e_data: begin
          if (link_v_i && data_ready_i) begin
            count_r <= count_r - 1'b1;
            if (count_r == 1) begin
              state_r <= e_idle;
            end
          end
        end
        default: begin
          state_r <= e_idle;
        end
      endcase
    end
  end

endmodule

//--- source/io_link_tile.sv
`timescale 1ns/10ps

module io_link_tile
  (input  logic                                          clk_i
   , input  logic                                        reset_i

   , input  logic [io_noc_pkg::did_width_lp-1:0]         host_did_i

   , input  logic                                        cmd_v_i
   , output logic                                        cmd_ready_o
   , input  logic [bedrock_mem_pkg::opcode_width_lp-1:0] cmd_opcode_i
   , input  logic [bedrock_mem_pkg::paddr_width_lp-1:0]  cmd_addr_i
   , input  logic [bedrock_mem_pkg::size_width_lp-1:0]   cmd_size_i

   , input  logic                                        cmd_data_v_i
   , input  logic [bedrock_mem_pkg::data_width_lp-1:0]   cmd_data_i
   , output logic                                        cmd_data_ready_o

   , output logic [io_noc_pkg::flit_width_lp-1:0]        io_cmd_link_data_o
   , output logic                                        io_cmd_link_v_o
   , input  logic                                        io_cmd_link_ready_i

   , input  logic [io_noc_pkg::flit_width_lp-1:0]        io_resp_link_data_i
   , input  logic                                        io_resp_link_v_i
   , output logic                                        io_resp_link_ready_o

   , output logic                                        resp_v_o
   , input  logic                                        resp_ready_i
   , output logic [bedrock_mem_pkg::opcode_width_lp-1:0] resp_opcode_o
   , output logic [bedrock_mem_pkg::paddr_width_lp-1:0]  resp_addr_o
   , output logic [bedrock_mem_pkg::size_width_lp-1:0]   resp_size_o

   , output logic                                        resp_data_v_o
   , output logic [bedrock_mem_pkg::data_width_lp-1:0]   resp_data_o
   , output logic                                        resp_last_o
   , input  logic                                        resp_data_ready_i
   );

  logic [io_noc_pkg::flit_width_lp-1:0] cmd_hdr_flit;

  io_cmd_encode encode
    (.host_did_i(host_did_i)
     ,.opcode_i(cmd_opcode_i)
     ,.addr_i(cmd_addr_i)
     ,.size_i(cmd_size_i)
     ,.hdr_flit_o(cmd_hdr_flit)
     );

  wormhole_sender sender
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.hdr_flit_i(cmd_hdr_flit)
     ,.hdr_v_i(cmd_v_i)
     ,.hdr_ready_o(cmd_ready_o)
     ,.data_i(cmd_data_i)
     ,.data_v_i(cmd_data_v_i)
     ,.data_ready_o(cmd_data_ready_o)
     ,.link_data_o(io_cmd_link_data_o)
     ,.link_v_o(io_cmd_link_v_o)
     ,.link_ready_i(io_cmd_link_ready_i)
     );

  wormhole_receiver receiver
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.link_data_i(io_resp_link_data_i)
     ,.link_v_i(io_resp_link_v_i)
     ,.link_ready_o(io_resp_link_ready_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_ready_i(resp_ready_i)
     ,.opcode_o(resp_opcode_o)
     ,.addr_o(resp_addr_o)
     ,.size_o(resp_size_o)
     ,.data_o(resp_data_o)
     ,.data_v_o(resp_data_v_o)
     ,.last_o(resp_last_o)
     ,.data_ready_i(resp_data_ready_i)
     );

endmodule

//--- verification/io_link_checker.sv
`timescale 1ns/10ps

module io_link_checker
  (input  logic                                          clk_i
   , input  logic                                        cmd_v_i
   , input  logic                                        cmd_ready_i
   , input  logic                                        cmd_data_ready_i
   , input  logic [io_noc_pkg::flit_width_lp-1:0]        link_data_i
   , input  logic                                        link_v_i
   , input  logic                                        link_ready_i
   , input  logic                                        resp_link_ready_i
   , input  logic                                        resp_v_i
   , input  logic                                        resp_ready_i
   , input  logic [bedrock_mem_pkg::opcode_width_lp-1:0] resp_opcode_i
   , input  logic [bedrock_mem_pkg::paddr_width_lp-1:0]  resp_addr_i
   , input  logic [bedrock_mem_pkg::size_width_lp-1:0]   resp_size_i
   , input  logic                                        resp_data_v_i
   , input  logic [bedrock_mem_pkg::data_width_lp-1:0]   resp_data_i
   , input  logic                                        resp_last_i
   , input  logic                                        resp_data_ready_i
   );

  string       test_name;
  logic        active = 1'b0;
  logic        hdr_pending;
  logic [1:0]  exp_opcode;
  logic [19:0] exp_addr;
  logic [1:0]  exp_size;
  logic [3:0]  exp_did;
  logic [31:0] exp_cmd_word;
  logic [31:0] exp_resp_word;
  int unsigned cmd_len;
  int unsigned resp_len;
  int unsigned cmd_flits;
  int unsigned resp_beats;
  int unsigned resp_hdrs;
  int unsigned errors;
  int unsigned pass_count = 0;
  int unsigned fail_count = 0;

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic finish_line();
    if (errors == 0) begin
      pass_count++;
      $display("%s: ok", test_name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", test_name, errors);
    end
  endtask

  task automatic check_reset();
    test_name = "reset_state";
    errors = 0;
    compare("cmd_ready", 1, cmd_ready_i);
    compare("cmd_data_ready", 0, cmd_data_ready_i);
    compare("cmd link valid", 0, link_v_i);
    compare("resp link ready", 1, resp_link_ready_i);
    compare("resp valid", 0, resp_v_i);
    compare("resp data valid", 0, resp_data_v_i);
    finish_line();
  endtask

  task automatic begin_test(input string name, input logic [1:0] op, input logic [19:0] addr,
                            input logic [1:0] size, input logic [3:0] did,
                            input logic [31:0] cmd_word, input logic [31:0] resp_word);
    test_name = name;
    exp_opcode = op;
    exp_addr = addr;
    exp_size = size;
    exp_did = did;
    exp_cmd_word = cmd_word;
    exp_resp_word = resp_word;
    // Writes carry data out and reads bring it back
    cmd_len = (op == bedrock_mem_pkg::mem_wr_lp) ? (1 << size) : 0;
    resp_len = (op == bedrock_mem_pkg::mem_rd_lp) ? (1 << size) : 0;
    cmd_flits = 0;
    resp_beats = 0;
    resp_hdrs = 0;
    errors = 0;
    hdr_pending = 1'b0;
    active = 1'b1;
  endtask

  task automatic end_test();
    active = 1'b0;
    compare("cmd flit count", cmd_len + 1, cmd_flits);
    compare("resp header count", 1, resp_hdrs);
    compare("resp beat count", resp_len, resp_beats);
    finish_line();
  endtask

  task automatic report();
    $display("Tests run %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
             fail_count);
  endtask

  function automatic bit all_passed();
    return (fail_count == 0) && (pass_count > 0);
  endfunction

  always @(posedge clk_i) begin
    if (active) begin
      if (hdr_pending && !link_v_i) begin
        $display("%s: header flit was not on the link one cycle after the command", test_name);
        errors++;
      end
      hdr_pending = cmd_v_i && cmd_ready_i;
      if (link_v_i && link_ready_i) begin
        if (cmd_flits == 0) begin
          compare("hdr did", exp_did, link_data_i[io_noc_pkg::hdr_did_lsb_lp +: 4]);
          compare("hdr len", cmd_len, link_data_i[io_noc_pkg::hdr_len_lsb_lp +: 4]);
          compare("hdr opcode", exp_opcode, link_data_i[io_noc_pkg::hdr_opcode_lsb_lp +: 2]);
          compare("hdr size", exp_size, link_data_i[io_noc_pkg::hdr_size_lsb_lp +: 2]);
          compare("hdr addr", exp_addr, link_data_i[io_noc_pkg::hdr_addr_lsb_lp +: 20]);
        end else if (cmd_flits <= cmd_len) begin
          compare("cmd data flit", exp_cmd_word + cmd_flits - 1, link_data_i);
        end else begin
          $display("%s: extra flit %h appeared on the command link", test_name, link_data_i);
          errors++;
        end
        cmd_flits++;
      end
      if (resp_v_i && resp_ready_i) begin
        compare("resp opcode", exp_opcode, resp_opcode_i);
        compare("resp addr", exp_addr, resp_addr_i);
        compare("resp size", exp_size, resp_size_i);
        resp_hdrs++;
      end
      if (resp_data_v_i && resp_data_ready_i) begin
        compare("resp data", exp_resp_word + resp_beats, resp_data_i);
        compare("resp last", (resp_beats + 1 == resp_len), resp_last_i);
        resp_beats++;
      end
    end
  end

endmodule

//--- verification/tb_io_link_tile.sv
`timescale 1ns/10ps

module tb_io_link_tile;

  localparam int unsigned max_tests_lp = 64;

  logic        clk_i;
  logic        reset_i;
  logic [3:0]  host_did_i;
  logic        cmd_v_i;
  logic        cmd_ready_o;
  logic [1:0]  cmd_opcode_i;
  logic [19:0] cmd_addr_i;
  logic [1:0]  cmd_size_i;
  logic        cmd_data_v_i;
  logic [31:0] cmd_data_i;
  logic        cmd_data_ready_o;
  logic [31:0] io_cmd_link_data_o;
  logic        io_cmd_link_v_o;
  logic        io_cmd_link_ready_i;
  logic [31:0] io_resp_link_data_i;
  logic        io_resp_link_v_i;
  logic        io_resp_link_ready_o;
  logic        resp_v_o;
  logic        resp_ready_i;
  logic [1:0]  resp_opcode_o;
  logic [19:0] resp_addr_o;
  logic [1:0]  resp_size_o;
  logic        resp_data_v_o;
  logic [31:0] resp_data_o;
  logic        resp_last_o;
  logic        resp_data_ready_i;

  string       names [max_tests_lp];
  logic [1:0]  opcodes [max_tests_lp];
  logic [19:0] addrs [max_tests_lp];
  logic [1:0]  sizes [max_tests_lp];
  logic [3:0]  host_dids [max_tests_lp];
  logic [3:0]  exp_dids [max_tests_lp];
  logic [31:0] cmd_words [max_tests_lp];
  logic [31:0] resp_words [max_tests_lp];
  int unsigned n_tests = 0;
  logic        loaded = 1'b0;
  integer      seed;

  io_link_tile UUT
    (.clk_i(clk_i), .reset_i(reset_i), .host_did_i(host_did_i)
     ,.cmd_v_i(cmd_v_i), .cmd_ready_o(cmd_ready_o), .cmd_opcode_i(cmd_opcode_i)
     ,.cmd_addr_i(cmd_addr_i), .cmd_size_i(cmd_size_i)
     ,.cmd_data_v_i(cmd_data_v_i), .cmd_data_i(cmd_data_i), .cmd_data_ready_o(cmd_data_ready_o)
     ,.io_cmd_link_data_o(io_cmd_link_data_o), .io_cmd_link_v_o(io_cmd_link_v_o)
     ,.io_cmd_link_ready_i(io_cmd_link_ready_i)
     ,.io_resp_link_data_i(io_resp_link_data_i), .io_resp_link_v_i(io_resp_link_v_i)
     ,.io_resp_link_ready_o(io_resp_link_ready_o)
     ,.resp_v_o(resp_v_o), .resp_ready_i(resp_ready_i), .resp_opcode_o(resp_opcode_o)
     ,.resp_addr_o(resp_addr_o), .resp_size_o(resp_size_o)
     ,.resp_data_v_o(resp_data_v_o), .resp_data_o(resp_data_o), .resp_last_o(resp_last_o)
     ,.resp_data_ready_i(resp_data_ready_i)
     );

  io_link_checker check
    (.clk_i(clk_i), .cmd_v_i(cmd_v_i), .cmd_ready_i(cmd_ready_o)
     ,.cmd_data_ready_i(cmd_data_ready_o)
     ,.link_data_i(io_cmd_link_data_o), .link_v_i(io_cmd_link_v_o)
     ,.link_ready_i(io_cmd_link_ready_i)
     ,.resp_link_ready_i(io_resp_link_ready_o)
     ,.resp_v_i(resp_v_o), .resp_ready_i(resp_ready_i), .resp_opcode_i(resp_opcode_o)
     ,.resp_addr_i(resp_addr_o), .resp_size_i(resp_size_o)
     ,.resp_data_v_i(resp_data_v_o), .resp_data_i(resp_data_o), .resp_last_i(resp_last_o)
     ,.resp_data_ready_i(resp_data_ready_i)
     );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Random stalls on about one cycle in four
  initial begin
    seed = 32'hb7a9;
    io_cmd_link_ready_i = 1'b0;
    resp_data_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (reset_i) begin
        io_cmd_link_ready_i <= 1'b0;
        resp_data_ready_i <= 1'b0;
      end else begin
        io_cmd_link_ready_i <= (($random(seed) & 3) != 0);
        resp_data_ready_i <= (($random(seed) & 3) != 0);
      end
    end
  end

  task automatic load_patterns(output bit opened);
    int    fd;
    int    n;
    string line;
    string name;
    int    op, addr, size, hdid, edid, cw, rw;
    fd = $fopen("verification/io_link_patterns.txt", "r");
    opened = (fd != 0);
    if (opened) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.substr(0, 0) != "#" && n_tests < max_tests_lp) begin
          if ($sscanf(line, "%s %h %h %h %h %h %h %h", name, op, addr, size, hdid, edid,
                      cw, rw) == 8) begin
            names[n_tests] = name;
            opcodes[n_tests] = op;
            addrs[n_tests] = addr;
            sizes[n_tests] = size;
            host_dids[n_tests] = hdid;
            exp_dids[n_tests] = edid;
            cmd_words[n_tests] = cw;
            resp_words[n_tests] = rw;
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_command(input int unsigned idx);
    cmd_v_i <= 1'b1;
    cmd_opcode_i <= opcodes[idx];
    cmd_addr_i <= addrs[idx];
    cmd_size_i <= sizes[idx];
    do @(posedge clk_i); while (!cmd_ready_o);
    cmd_v_i <= 1'b0;
  endtask

  task automatic send_cmd_data(input logic [31:0] word, input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      cmd_data_v_i <= 1'b1;
      cmd_data_i <= word + i;
      do @(posedge clk_i); while (!cmd_data_ready_o);
    end
    cmd_data_v_i <= 1'b0;
  endtask

  task automatic collect_cmd_flits(input int unsigned n);
    int unsigned count;
    count = 0;
    while (count < n) begin
      @(posedge clk_i);
      if (io_cmd_link_v_o && io_cmd_link_ready_i) begin
        count++;
      end
    end
  endtask

  // Host side echoes the header fields back with the read data
  task automatic send_response(input int unsigned idx, input int unsigned n);
    logic [31:0] flit;
    flit = '0;
    flit[io_noc_pkg::hdr_len_lsb_lp +: 4] = n;
    flit[io_noc_pkg::hdr_opcode_lsb_lp +: 2] = opcodes[idx];
    flit[io_noc_pkg::hdr_size_lsb_lp +: 2] = sizes[idx];
    flit[io_noc_pkg::hdr_addr_lsb_lp +: 20] = addrs[idx];
    io_resp_link_v_i <= 1'b1;
    io_resp_link_data_i <= flit;
    do @(posedge clk_i); while (!io_resp_link_ready_o);
    for (int unsigned i = 0; i < n; i++) begin
      io_resp_link_data_i <= resp_words[idx] + i;
      do @(posedge clk_i); while (!io_resp_link_ready_o);
    end
    io_resp_link_v_i <= 1'b0;
  endtask

  task automatic wait_response(input int unsigned n);
    if (n == 0) begin
      do @(posedge clk_i); while (!(resp_v_o && resp_ready_i));
    end else begin
      do @(posedge clk_i); while (!(resp_data_v_o && resp_data_ready_i && resp_last_o));
    end
  endtask

  task automatic run_test(input int unsigned idx);
    int unsigned cmd_len;
    int unsigned resp_len;
    cmd_len = (opcodes[idx] == bedrock_mem_pkg::mem_wr_lp) ? (1 << sizes[idx]) : 0;
    resp_len = (opcodes[idx] == bedrock_mem_pkg::mem_rd_lp) ? (1 << sizes[idx]) : 0;
    check.begin_test(names[idx], opcodes[idx], addrs[idx], sizes[idx], exp_dids[idx],
                     cmd_words[idx], resp_words[idx]);
    @(posedge clk_i);
    host_did_i <= host_dids[idx];
    fork
      send_command(idx);
      send_cmd_data(cmd_words[idx], cmd_len);
      collect_cmd_flits(cmd_len + 1);
    join
    fork
      send_response(idx, resp_len);
      wait_response(resp_len);
    join
    @(negedge clk_i);
    check.end_test();
  endtask

  // Watchdog scaled by the number of tests
  initial begin
    longint timeout_ns;
    wait (loaded);
    timeout_ns = longint'(n_tests) * (2 * bedrock_mem_pkg::max_beats_lp + 40) * 8 * 4;
    #(timeout_ns);
    $display("Timeout after %0d ns, the tests did not finish", timeout_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    bit opened;
    reset_i = 1'b1;
    host_did_i = '0;
    cmd_v_i = 1'b0;
    cmd_opcode_i = '0;
    cmd_addr_i = '0;
    cmd_size_i = '0;
    cmd_data_v_i = 1'b0;
    cmd_data_i = '0;
    io_resp_link_data_i = '0;
    io_resp_link_v_i = 1'b0;
    resp_ready_i = 1'b1;
    load_patterns(opened);
    if (!opened) begin
      $display("Could not open the pattern file");
      $display("TEST FAIL");
    end else begin
      loaded = 1'b1;
      repeat (2) @(posedge clk_i);
      reset_i <= 1'b0;
      @(negedge clk_i);
      check.check_reset();
      for (int unsigned i = 0; i < n_tests; i++) begin
        run_test(i);
      end
      check.report();
      if (check.all_passed()) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
    end
    $finish;
  end

endmodule

//--- verification/io_link_patterns.txt
# name opcode addr size host_did exp_did cmd_word resp_word (all but name in hex)
# opcode 0 is a read, 1 is a write; size s means 2^s beats
rd_local_boot      0 00120 0 3 3 00000000 a0000000
rd_local_host      0 00800 2 3 3 00000000 a1000010
rd_local_dev2      0 29000 1 3 5 00000000 a2000020
rd_boot_host0      0 00000 0 0 0 00000000 a3000030
rd_global_hio_f    0 f8004 3 4 f 00000000 a4000040
rd_global_dev1     0 80800 1 c 0 00000000 a5000050
wr_global_hio_7    1 b8000 2 3 7 c0000100 00000000
wr_global_hio_a    1 d0123 3 1 a c1000200 00000000
wr_local_host      1 00840 1 9 9 c2000300 00000000
wr_global_hio_2    1 90010 0 5 2 c3000400 00000000
wr_local_dev3      1 31800 2 9 6 c4000500 00000000
wr_wrap_data       1 80004 3 2 0 fffffffc 00000000
rd_wrap_data       0 c8010 2 2 9 00000000 fffffffe

//--- tb.f
source/io_noc_pkg.sv
source/bedrock_mem_pkg.sv
source/io_cmd_encode.sv
source/wormhole_sender.sv
source/wormhole_receiver.sv
source/io_link_tile.sv
verification/io_link_checker.sv
verification/tb_io_link_tile.sv

//--- Bender.yml
package:
  name: io_link_tile

sources:
  - source/io_noc_pkg.sv
  - source/bedrock_mem_pkg.sv
  - source/io_cmd_encode.sv
  - source/wormhole_sender.sv
  - source/wormhole_receiver.sv
  - source/io_link_tile.sv
  - target: test
    files:
      - verification/io_link_checker.sv
      - verification/tb_io_link_tile.sv
